/* vlog.f */
+incdir+hw
hw/pixel_pkg.sv
hw/seq_pkg.sv
hw/hue_ctrl_fsm.sv
hw/hue_step_counter.sv
hw/channel_ramp.sv
hw/shift_add_mult.sv
hw/pixel_output.sv
hw/rgbw_color_gen.sv
tests/rgbw_color_gen_sva.sv
tests/tb_rgbw_color_gen.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_rgbw_color_gen
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/tb_rgbw_color_gen.sv */
`timescale 1ns/100ps
`include "rgbw_defines.svh"

module tb_rgbw_color_gen
    import pixel_pkg::*;
();

    localparam int RESET_CYCLES = 8;
    // per-entry budget, longest hue request is under 300 cycles
    localparam int WAIT_LIMIT = 350;
    // quiet window for modes the core ignores
    localparam int IGNORE_WIN = 20;
    localparam int NUM_RANDOM = 12;
    // white add, four multiplies of start plus 9, emit, output register
    localparam int HUE_OVERHEAD = 1 + 4 * 10 + 2;
    localparam int FULL = (1 << `CH_W) - 1;
    localparam logic [31:0] SEED = 32'hb829_30b5;
    localparam logic [`CH_W-1:0] MODE_NONE = 8'h00;

    // one table row, request plus the pixel on pix_in
    typedef struct packed {
        request_t req;
        pixel_t   pix;
    } stim_t;

    logic     clk = 1'b0;
    logic     reset;
    request_t req;
    pixel_t   pix_in;
    pixel_t   pix_out;
    logic     pix_valid;

    stim_t       table_q[$];
    string       name_q[$];
    // expected pix_out, tracked from the rules
    pixel_t      model_out;
    logic [31:0] rand_state;
    int          cycle_cnt = 0;
    int          cycle_limit = 1000000;

    rgbw_color_gen DUT (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .pix_in    (pix_in),
        .pix_out   (pix_out),
        .pix_valid (pix_valid)
    );

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (act !== exp)
        begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp)
        begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // outputs settle at the edge, inputs change right after
    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // ramp length, hue index held to 1..MAX_STEPS
    function automatic int clamp_steps(input logic [`CH_W-1:0] h);
        if (h == '0)
            return 1;
        else if (int'(h) > `MAX_STEPS)
            return `MAX_STEPS;
        else
            return int'(h);
    endfunction

    function automatic int ramp_up(input int v);
        return (v + `HUE_STEP > FULL) ? FULL : v + `HUE_STEP;
    endfunction

    function automatic int ramp_down(input int v);
        return (v < `HUE_STEP) ? 0 : v - `HUE_STEP;
    endfunction

    function automatic int white_sat(input int v, input int w);
        return (v + w > FULL) ? FULL : v + w;
    endfunction

    // upper byte of the full product
    function automatic logic [`CH_W-1:0] scale_byte(input int k, input int v);
        return `CH_W'((k * v) >> `CH_W);
    endfunction

    // expected pixel of a hue request
    function automatic pixel_t ref_pixel(input request_t r);
        int     red;
        int     green;
        int     blue;
        int     wl;
        int     sec;
        pixel_t p;
        red   = 0;
        green = 0;
        blue  = 0;
        for (int i = 1; i <= clamp_steps(r.hue_idx); i++)
        begin
            sec = (i - 1) / `SECTOR_LEN;
            case (sec)
                0:
                begin
                    red   = FULL;
                    green = 0;
                    blue  = ramp_up(blue);
                end
                1:
                begin
                    blue  = FULL;
                    green = 0;
                    red   = ramp_down(red);
                end
                2:
                begin
                    blue  = FULL;
                    red   = 0;
                    green = ramp_up(green);
                end
                3:
                begin
                    green = FULL;
                    red   = 0;
                    blue  = ramp_down(blue);
                end
                4:
                begin
                    green = FULL;
                    blue  = 0;
                    red   = ramp_up(red);
                end
                // sector 5
                default:
                begin
                    red   = FULL;
                    blue  = 0;
                    green = ramp_down(green);
                end
            endcase
        end
        wl      = int'(r.white_lvl);
        red     = white_sat(red, wl);
        green   = white_sat(green, wl);
        blue    = white_sat(blue, wl);
        p.white = scale_byte(int'(r.intensity), wl);
        p.red   = scale_byte(int'(r.intensity), red);
        p.green = scale_byte(int'(r.intensity), green);
        p.blue  = scale_byte(int'(r.intensity), blue);
        return p;
    endfunction

    task automatic add_entry(input string name, input logic [`CH_W-1:0] mode,
                             input logic [`CH_W-1:0] hue, input logic [`CH_W-1:0] white,
                             input logic [`CH_W-1:0] inten, input pixel_t pix);
        stim_t s;
        s.req.mode      = mode;
        s.req.hue_idx   = hue;
        s.req.white_lvl = white;
        s.req.intensity = inten;
        s.pix           = pix;
        table_q.push_back(s);
        name_q.push_back(name);
    endtask

    task automatic add_random_entries(input int count);
        stim_t s;
        for (int k = 0; k < count; k++)
        begin
            rand_state      = lcg_next(rand_state);
            s.req.mode      = `MODE_HUE;
            s.req.hue_idx   = rand_state[31:24];
            s.req.white_lvl = rand_state[23:16];
            s.req.intensity = rand_state[15:8];
            rand_state      = lcg_next(rand_state);
            s.pix           = rand_state;
            table_q.push_back(s);
            name_q.push_back($sformatf("random_%0d", k));
        end
    endtask

    task automatic build_table();
        int hue_list[$] = '{1, 41, 42, 43, 84, 126, 168, 210, 252, 255};
        add_entry("pass_basic", `MODE_PASS, 8'd0, 8'd0, 8'd0, 32'h1122_3344);
        add_entry("pass_fields_ignored", `MODE_PASS, 8'd200, 8'hff, 8'h10, 32'hdead_beef);
        // every sector edge, no white, full scale
        foreach (hue_list[k])
        begin
            add_entry($sformatf("hue_%0d", hue_list[k]), `MODE_HUE,
                      `CH_W'(hue_list[k]), 8'h00, 8'hff, 32'h5a5a_5a5a);
        end
        add_entry("white_sat_high", `MODE_HUE, 8'd60, 8'hf0, 8'hff, 32'h0);
        add_entry("white_sat_mid", `MODE_HUE, 8'd200, 8'h80, 8'hff, 32'h0);
        add_entry("white_full", `MODE_HUE, 8'd130, 8'hff, 8'hff, 32'h0);
        add_entry("scale_zero", `MODE_HUE, 8'd100, 8'h30, 8'h00, 32'h0);
        add_entry("scale_half", `MODE_HUE, 8'd100, 8'h30, 8'h80, 32'h0);
        add_entry("scale_half_idx0", `MODE_HUE, 8'd0, 8'h00, 8'h80, 32'h0);
        add_entry("mode_unknown_55", 8'h55, 8'd10, 8'h20, 8'hff, 32'hffff_ffff);
        add_entry("mode_unknown_a5", 8'ha5, 8'd42, 8'h00, 8'hff, 32'h1234_5678);
        add_entry("mode_unknown_20", 8'h20, 8'd7, 8'h00, 8'h40, 32'h8765_4321);
        add_entry("pass_after_unknown", `MODE_PASS, 8'd0, 8'd0, 8'd0, 32'h0f1e_2d3c);
        add_random_entries(NUM_RANDOM);
    endtask

    task automatic run_entry(input string name, input stim_t s);
        int     lat;
        int     exp_lat;
        pixel_t exp_pix;
        req    = s.req;
        pix_in = s.pix;
        next_cycle();
        // one idle sample only
        req      = '0;
        req.mode = MODE_NONE;
        if (s.req.mode == `MODE_PASS || s.req.mode == `MODE_HUE)
        begin
            if (s.req.mode == `MODE_PASS)
            begin
                exp_pix = s.pix;
                exp_lat = 1;
            end
            else
            begin
                exp_pix = ref_pixel(s.req);
                exp_lat = clamp_steps(s.req.hue_idx) + HUE_OVERHEAD;
            end
            lat = 1;
            while (!pix_valid)
            begin
                if (lat >= WAIT_LIMIT)
                begin
                    $display("%s: pix_valid did not arrive within %0d cycles", name, WAIT_LIMIT);
                    abort_run();
                end
                else
                begin
                    next_cycle();
                    lat++;
                end
            end
            check_latency({name, " latency"}, exp_lat, lat);
            check_pixel(name, exp_pix, pix_out);
            model_out = exp_pix;
            next_cycle();
            // single pulse, value held
            check_valid({name, " pulse end"}, 1'b0, pix_valid);
            check_pixel({name, " hold"}, model_out, pix_out);
        end
        else
        begin
            repeat (IGNORE_WIN)
            begin
                check_valid(name, 1'b0, pix_valid);
                check_pixel(name, model_out, pix_out);
                next_cycle();
            end
        end
    endtask

    always #2 clk = ~clk;

    // run length guard
    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
        begin
            $display("timeout: run went past %0d clock cycles", cycle_limit);
            abort_run();
        end
    end

    initial
    begin
        reset      = 1'b0;
        req        = '0;
        pix_in     = '0;
        model_out  = '0;
        rand_state = SEED;
        build_table();
        cycle_limit = table_q.size() * WAIT_LIMIT + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        reset = 1'b1;
        check_pixel("after_reset", '0, pix_out);
        check_valid("after_reset", 1'b0, pix_valid);
        for (int i = 0; i < table_q.size(); i++)
        begin
            run_entry(name_q[i], table_q[i]);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* tests/rgbw_color_gen_sva.sv */
`timescale 1ns/100ps

module rgbw_color_gen_sva
(
    input logic clk,
    input logic reset,
    input logic step_clear,
    input logic step_en,
    input logic rgb_clear,
    input logic ramp_step,
    input logic white_add,
    input logic mul_start,
    input logic mul_done,
    input logic pass_load,
    input logic emit
);

    logic in_flight;
    logic reset_seen;

    // multiply outstanding from start until done
    always_ff @(posedge clk)
    begin
        if (!reset)
            in_flight <= 1'b0;
        else if (mul_start)
            in_flight <= 1'b1;
        else if (mul_done)
            in_flight <= 1'b0;
    end

    // skips the very first edge, state still unknown there
    always_ff @(posedge clk)
    begin
        if (!reset)
            reset_seen <= 1'b1;
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!reset)
        mul_start |-> !in_flight)
        else $error("mul_start while a multiply is in flight");

    a_done_delay: assert property (@(posedge clk) disable iff (!reset)
        mul_start |-> ##9 mul_done)
        else $error("mul_done missing 9 cycles after mul_start");

    // pix_valid is the registered or of both load strobes
    a_valid_pulse: assert property (@(posedge clk) disable iff (!reset)
        (pass_load || emit) |=> !(pass_load || emit))
        else $error("pix_valid held longer than one cycle");

    a_reset_quiet: assert property (@(posedge clk)
        (!reset && reset_seen) |-> !(step_clear || step_en || rgb_clear || ramp_step ||
                                     white_add || mul_start || mul_done ||
                                     pass_load || emit))
        else $error("strobe active during reset");

endmodule

bind hue_ctrl_fsm rgbw_color_gen_sva u_sva (.*);

/* hw/rgbw_color_gen.sv */
`timescale 1ns/100ps
`include "rgbw_defines.svh"

module rgbw_color_gen
    import pixel_pkg::*, seq_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  request_t req,
    input  pixel_t   pix_in,
    output pixel_t   pix_out,
    output logic     pix_valid
);

    request_t           cap_req;
    sector_t            sector;
    chan_sel_t          mul_sel;
    pixel_t             rgb_work;
    logic [`CH_W-1:0]   mul_b;
    logic [`PROD_W-1:0] product;
    logic               ramp_last;
    logic               step_clear;
    logic               step_en;
    logic               rgb_clear;
    logic               ramp_step;
    logic               white_add;
    logic               mul_start;
    logic               mul_done;
    logic               pass_load;
    logic               emit;

    hue_ctrl_fsm u_fsm (.*);

    // counter sees the captured hue index
    hue_step_counter u_counter (
        .clk, .reset, .step_clear, .step_en,
        .hue_idx(cap_req.hue_idx), .sector, .ramp_last
    );

    channel_ramp u_ramp (
        .clk, .reset, .rgb_clear, .ramp_step, .white_add, .sector,
        .white_lvl(cap_req.white_lvl), .rgb_work
    );

    // intensity always on a, channel on b
    shift_add_mult u_mult (
        .clk, .reset, .mul_start, .a(cap_req.intensity), .b(mul_b),
        .product, .mul_done
    );

    pixel_output u_out (.*);

endmodule

/* hw/pixel_output.sv */
`timescale 1ns/100ps
`include "rgbw_defines.svh"

module pixel_output
    import pixel_pkg::*, seq_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               mul_done,
    input  chan_sel_t          mul_sel,
    input  logic [`PROD_W-1:0] product,
    input  logic               pass_load,
    input  logic               emit,
    input  pixel_t             pix_in,
    output pixel_t             pix_out,
    output logic               pix_valid
);

    pixel_t           staging;
    logic [`CH_W-1:0] prod_hi;

    // scaled value is the upper product byte
    assign prod_hi = product[`PROD_W-1 -: `CH_W];

    // collect the four scaled channels
    always_ff @(posedge clk)
    begin
        if (mul_done)
        begin
            case (mul_sel)
                sel_white: staging.white <= prod_hi;
                sel_red:   staging.red   <= prod_hi;
                sel_green: staging.green <= prod_hi;
                default:   staging.blue  <= prod_hi;
            endcase
        end
    end

    // output pixel, valid pulses with every update
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            pix_out   <= '0;
            pix_valid <= 1'b0;
        end
        else
        begin
            pix_valid <= pass_load || emit;
            if (pass_load)
                pix_out <= pix_in;
            else if (emit)
                pix_out <= staging;
        end
    end

endmodule

/* hw/shift_add_mult.sv */
`timescale 1ns/100ps
`include "rgbw_defines.svh"

module shift_add_mult
(
    input  logic               clk,
    input  logic               reset,
    input  logic               mul_start,
    input  logic [`CH_W-1:0]   a,
    input  logic [`CH_W-1:0]   b,
    output logic [`PROD_W-1:0] product,
    output logic               mul_done
);

    localparam int CNT_W = $clog2(`CH_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`CH_W - 1);

    logic [`PROD_W-1:0] mcand;
    logic [`CH_W-1:0]   mplier;
    logic [`PROD_W-1:0] acc;
    logic [CNT_W-1:0]   bit_cnt;
    logic               busy;

    // control, 8 busy cycles then a done pulse
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            busy     <= 1'b0;
            mul_done <= 1'b0;
            bit_cnt  <= '0;
        end
        else
        begin
            mul_done <= 1'b0;
            if (mul_start)
            begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end
            else if (busy)
            begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == LAST_BIT)
                begin
                    busy     <= 1'b0;
                    mul_done <= 1'b1;
                end
            end
        end
    end

    // one partial product per cycle, lsb of b first
    always_ff @(posedge clk)
    begin
        if (mul_start)
        begin
            mcand  <= {{(`PROD_W-`CH_W){1'b0}}, a};
            mplier <= b;
            acc    <= '0;
        end
        else if (busy)
        begin
            if (mplier[0])
                acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // holds until the next start
    assign product = acc;

endmodule

/* hw/channel_ramp.sv */
`timescale 1ns/100ps
`include "rgbw_defines.svh"

module channel_ramp
    import pixel_pkg::*, seq_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             rgb_clear,
    input  logic             ramp_step,
    input  logic             white_add,
    input  sector_t          sector,
    input  logic [`CH_W-1:0] white_lvl,
    output pixel_t           rgb_work
);

    localparam logic [`CH_W:0]   STEP = `HUE_STEP;
    localparam logic [`CH_W-1:0] FULL = {`CH_W{1'b1}};

    logic [`CH_W-1:0] red;
    logic [`CH_W-1:0] green;
    logic [`CH_W-1:0] blue;

    // rising step, clip at full scale
    function automatic logic [`CH_W-1:0] step_up(input logic [`CH_W-1:0] v);
        logic [`CH_W:0] sum;
        sum = {1'b0, v} + STEP;
        return sum[`CH_W] ? FULL : sum[`CH_W-1:0];
    endfunction

    // falling step, floor at zero
    function automatic logic [`CH_W-1:0] step_down(input logic [`CH_W-1:0] v);
        logic [`CH_W:0] diff;
        diff = {1'b0, v} - STEP;
        return diff[`CH_W] ? '0 : diff[`CH_W-1:0];
    endfunction

    // white add, carry bit flags overflow
    function automatic logic [`CH_W-1:0] add_white(input logic [`CH_W-1:0] v,
                                                   input logic [`CH_W-1:0] w);
        logic [`CH_W:0] sum;
        sum = {1'b0, v} + {1'b0, w};
        return sum[`CH_W] ? FULL : sum[`CH_W-1:0];
    endfunction

    always_ff @(posedge clk)
    begin
        if (!reset || rgb_clear)
        begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
        else if (ramp_step)
        begin
            // two channels pinned, one moves
            case (sector)
                sec_red_blue_up:
                begin
                    red   <= FULL;
                    green <= '0;
                    blue  <= step_up(blue);
                end
                sec_blue_red_down:
                begin
                    blue  <= FULL;
                    green <= '0;
                    red   <= step_down(red);
                end
                sec_blue_green_up:
                begin
                    blue  <= FULL;
                    red   <= '0;
                    green <= step_up(green);
                end
                sec_green_blue_down:
                begin
                    green <= FULL;
                    red   <= '0;
                    blue  <= step_down(blue);
                end
                sec_green_red_up:
                begin
                    green <= FULL;
                    blue  <= '0;
                    red   <= step_up(red);
                end
                sec_red_green_down:
                begin
                    red   <= FULL;
                    blue  <= '0;
                    green <= step_down(green);
                end
                default:
                begin
                    red <= red;
                end
            endcase
        end
        else if (white_add)
        begin
            red   <= add_white(red, white_lvl);
            green <= add_white(green, white_lvl);
            blue  <= add_white(blue, white_lvl);
        end
    end

    // white byte is the captured level itself
    assign rgb_work = '{white: white_lvl, red: red, green: green, blue: blue};

endmodule

/* hw/hue_step_counter.sv */
`timescale 1ns/100ps
`include "rgbw_defines.svh"

module hue_step_counter
    import seq_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             step_clear,
    input  logic             step_en,
    input  logic [`CH_W-1:0] hue_idx,
    output sector_t          sector,
    output logic             ramp_last
);

    localparam int IN_W = $clog2(`SECTOR_LEN);
    localparam logic [IN_W-1:0] SEC_END = IN_W'(`SECTOR_LEN - 1);
    localparam logic [`CH_W-1:0] MAX_N = `CH_W'(`MAX_STEPS);
    localparam sector_t LAST_SEC = sector_t'(`NUM_SECTORS - 1);

    logic [`CH_W-1:0] step_cnt;
    logic [IN_W-1:0]  in_cnt;
    logic [`CH_W-1:0] target;

    // clamp hue index to 1..MAX_STEPS
    always_comb
    begin
        if (hue_idx == '0)
            target = `CH_W'(1);
        else if (hue_idx > MAX_N)
            target = MAX_N;
        else
            target = hue_idx;
    end

    // step_cnt is the index of the step about to run
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            step_cnt <= '0;
            in_cnt   <= '0;
            sector   <= sec_red_blue_up;
        end
        else if (step_clear)
        begin
            step_cnt <= `CH_W'(1);
            in_cnt   <= '0;
            sector   <= sec_red_blue_up;
        end
        else if (step_en)
        begin
            step_cnt <= step_cnt + 1'b1;
            // 42 steps per sector, no divider
            if (in_cnt == SEC_END)
            begin
                in_cnt <= '0;
                if (sector != LAST_SEC)
                    sector <= sector_t'(sector + 3'd1);
            end
            else
            begin
                in_cnt <= in_cnt + 1'b1;
            end
        end
    end

    // high while the final step is running
    assign ramp_last = (step_cnt == target);

endmodule

/* hw/hue_ctrl_fsm.sv */
`timescale 1ns/100ps
`include "rgbw_defines.svh"

module hue_ctrl_fsm
    import pixel_pkg::*, seq_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  request_t         req,
    input  sector_t          sector,
    input  logic             ramp_last,
    input  logic             mul_done,
    input  pixel_t           rgb_work,
    output logic             step_clear,
    output logic             step_en,
    output logic             rgb_clear,
    output logic             ramp_step,
    output logic             white_add,
    output chan_sel_t        mul_sel,
    output logic             mul_start,
    output logic [`CH_W-1:0] mul_b,
    output logic             pass_load,
    output logic             emit,
    output request_t         cap_req
);

    gen_state_t state;
    gen_state_t state_next;
    logic       start_mul;

    // next state and strobe decode
    always_comb
    begin
        state_next = state;
        step_clear = 1'b0;
        step_en    = 1'b0;
        rgb_clear  = 1'b0;
        ramp_step  = 1'b0;
        white_add  = 1'b0;
        pass_load  = 1'b0;
        emit       = 1'b0;
        mul_sel    = sel_white;
        case (state)
            st_idle:
            begin
                // passthrough needs no state of its own
                if (req.mode == `MODE_PASS)
                begin
                    pass_load = 1'b1;
                end
                else if (req.mode == `MODE_HUE)
                begin
                    step_clear = 1'b1;
                    rgb_clear  = 1'b1;
                    state_next = st_ramp;
                end
            end
            st_ramp:
            begin
                // one wheel step per cycle, counter flags the final one
                step_en   = 1'b1;
                ramp_step = 1'b1;
                if (ramp_last)
                begin
                    state_next = st_white_sat;
                end
            end
            st_white_sat:
            begin
                white_add  = 1'b1;
                state_next = st_mul_w;
            end
            st_mul_w:
            begin
                mul_sel = sel_white;
                if (mul_done)
                begin
                    state_next = st_mul_r;
                end
            end
            st_mul_r:
            begin
                mul_sel = sel_red;
                if (mul_done)
                begin
                    state_next = st_mul_g;
                end
            end
            st_mul_g:
            begin
                mul_sel = sel_green;
                if (mul_done)
                begin
                    state_next = st_mul_b;
                end
            end
            st_mul_b:
            begin
                mul_sel = sel_blue;
                if (mul_done)
                begin
                    state_next = st_emit;
                end
            end
            st_emit:
            begin
                emit       = 1'b1;
                state_next = st_idle;
            end
            default:
            begin
                state_next = st_idle;
            end
        endcase
    end

    // fire the multiplier once on entry to each mul state
    assign start_mul = (state_next != state) &&
                       (state_next inside {st_mul_w, st_mul_r, st_mul_g, st_mul_b});

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state     <= st_idle;
            mul_start <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            mul_start <= start_mul;
        end
    end

    // request copy, frozen once we leave idle
    always_ff @(posedge clk)
    begin
        if (state == st_idle)
        begin
            cap_req <= req;
        end
    end

    // b operand mux, white byte holds the captured level
    always_comb
    begin
        case (mul_sel)
            sel_white: mul_b = rgb_work.white;
            sel_red:   mul_b = rgb_work.red;
            sel_green: mul_b = rgb_work.green;
            default:   mul_b = rgb_work.blue;
        endcase
    end

endmodule

/* hw/seq_pkg.sv */
package seq_pkg;

    // main sequencer states
    typedef enum logic [2:0] {
        st_idle, st_ramp, st_white_sat,
        st_mul_w, st_mul_r, st_mul_g, st_mul_b,
        st_emit
    } gen_state_t;

    // wheel sectors, named pinned-high channel then moving channel
    typedef enum logic [2:0] {
        sec_red_blue_up, sec_blue_red_down, sec_blue_green_up,
        sec_green_blue_down, sec_green_red_up, sec_red_green_down
    } sector_t;

    // channel routed into the multiplier
    typedef enum logic [1:0] {
        sel_white, sel_red, sel_green, sel_blue
    } chan_sel_t;

endpackage

/* hw/pixel_pkg.sv */
`include "rgbw_defines.svh"

package pixel_pkg;

    // one RGBW pixel, white in the top byte
    typedef struct packed {
        logic [`CH_W-1:0] white;
        logic [`CH_W-1:0] red;
        logic [`CH_W-1:0] green;
        logic [`CH_W-1:0] blue;
    } pixel_t;

    // colour request as seen on the input pins
    typedef struct packed {
        logic [`CH_W-1:0] mode;
        // number of ramp steps, clamped later
        logic [`CH_W-1:0] hue_idx;
        logic [`CH_W-1:0] white_lvl;
        // final brightness scale
        logic [`CH_W-1:0] intensity;
    } request_t;

endpackage

/* hw/rgbw_defines.svh */
`ifndef RGBW_DEFINES_SVH
`define RGBW_DEFINES_SVH

// one colour channel
`define CH_W 8

// full 8x8 product
`define PROD_W 16

// channel change per ramp step
`define HUE_STEP 7

// ramp steps per wheel sector
`define SECTOR_LEN 42

// sectors around the wheel
`define NUM_SECTORS 6

// longest ramp, one full turn
`define MAX_STEPS (`SECTOR_LEN * `NUM_SECTORS)

// request mode codes
`define MODE_PASS 8'h21
`define MODE_HUE 8'hA4

`endif
